// File: fftPkg.sv
`default_nettype none

package fftPkg;

    localparam int nPoints  = 16;           // samples per frame
    localparam int addrBits = 4;            // log2 of nPoints
    localparam int nStages  = 4;            // radix-2 stages per transform

    typedef logic signed [15:0] sample_t;   // Q1.15

    typedef struct packed {
        sample_t im;                        // upper half of a word
        sample_t re;                        // lower half
    } cplx_t;

    // host side and memory see raw words and the engine decodes them as complex
    typedef union packed {
        logic [31:0] raw;
        cplx_t       c;
    } ramWord_u;

    typedef struct packed {
        logic                req;
        logic                we;
        logic [addrBits-1:0] addr;
        ramWord_u            wdata;
    } memReq_t;

endpackage

`default_nettype wire

// File: twiddleRom.sv
`timescale 1ns/10ps
`default_nettype none

module twiddleRom (
    input  wire logic       clk,
    input  wire logic [2:0] index,
    input  wire logic       inverse,
    output fftPkg::cplx_t   twiddle
);

    fftPkg::cplx_t base;

    // entry k is cos and -sin of 2*pi*k/16 scaled by 32767
    always_comb begin
        case (index)
            3'd0:    base = '{im: 16'sd0,      re: 16'sd32767};
            3'd1:    base = '{im: -16'sd12539, re: 16'sd30273};
            3'd2:    base = '{im: -16'sd23170, re: 16'sd23170};
            3'd3:    base = '{im: -16'sd30273, re: 16'sd12539};
            3'd4:    base = '{im: -16'sd32767, re: 16'sd0};
            3'd5:    base = '{im: -16'sd30273, re: -16'sd12539};
            3'd6:    base = '{im: -16'sd23170, re: -16'sd23170};
            default: base = '{im: -16'sd12539, re: -16'sd30273};
        endcase
    end

    always_ff @(posedge clk) begin
        twiddle.re <= base.re;
        twiddle.im <= inverse ? -base.im : base.im;     // conjugate for the IFFT
    end

endmodule

`default_nettype wire

// File: butterflyUnit.sv
`timescale 1ns/10ps
`default_nettype none

module butterflyUnit (
    input  wire fftPkg::cplx_t a,
    input  wire fftPkg::cplx_t b,
    input  wire fftPkg::cplx_t twiddle,
    output fftPkg::cplx_t      outA,
    output fftPkg::cplx_t      outB
);

    logic signed [31:0] prodRR;
    logic signed [31:0] prodII;
    logic signed [31:0] prodRI;
    logic signed [31:0] prodIR;
    logic signed [17:0] tRe;                            // t = b * twiddle
    logic signed [17:0] tIm;
    logic signed [17:0] sumRe;
    logic signed [17:0] sumIm;
    logic signed [17:0] difRe;
    logic signed [17:0] difIm;

    always_comb begin
        prodRR = b.re * twiddle.re;
        prodII = b.im * twiddle.im;
        prodRI = b.re * twiddle.im;
        prodIR = b.im * twiddle.re;
        tRe    = 18'(prodRR >>> 15) - 18'(prodII >>> 15);   // each product truncated
        tIm    = 18'(prodRI >>> 15) + 18'(prodIR >>> 15);
        sumRe  = 18'(a.re) + tRe;
        sumIm  = 18'(a.im) + tIm;
        difRe  = 18'(a.re) - tRe;
        difIm  = 18'(a.im) - tIm;
        outA.re = 16'(sumRe >>> 1);                     // halve every stage
        outA.im = 16'(sumIm >>> 1);
        outB.re = 16'(difRe >>> 1);
        outB.im = 16'(difIm >>> 1);
    end

endmodule

`default_nettype wire

// File: fftEngine.sv
`timescale 1ns/10ps
`default_nettype none

module fftEngine (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,
    input  wire logic             inverse,
    output fftPkg::memReq_t       reqA,
    output fftPkg::memReq_t       reqB,
    input  wire logic             grant,
    input  wire fftPkg::ramWord_u rdA,
    input  wire fftPkg::ramWord_u rdB,
    output logic                  engineDone
);

    logic                                 running;
    logic                                 writePhase;   // second cycle of a butterfly
    logic [$clog2(fftPkg::nStages)-1:0]   stage;
    logic [fftPkg::addrBits-2:0]          pair;
    logic [fftPkg::addrBits-1:0]          span;
    logic [fftPkg::addrBits-1:0]          offset;
    logic [fftPkg::addrBits-1:0]          idxLo;
    logic [fftPkg::addrBits-1:0]          idxHi;
    logic [2:0]                           twIdx;
    logic                                 lastBfly;
    fftPkg::cplx_t                        twiddle;
    fftPkg::cplx_t                        outA;
    fftPkg::cplx_t                        outB;

    ////////////////////////////////////////
    // address generation
    always_comb begin
        span   = {{(fftPkg::addrBits-1){1'b0}}, 1'b1} << stage;
        offset = {1'b0, pair} & (span - 1'b1);
        idxLo  = (({1'b0, pair} >> stage) << (stage + 1)) | offset;
        idxHi  = idxLo + span;
        twIdx  = 3'(offset << (fftPkg::nStages - 1 - stage));
    end

    always_comb begin
        reqA.req     = running;
        reqA.we      = writePhase;
        reqA.addr    = idxLo;
        reqA.wdata.c = outA;
        reqB.req     = running;
        reqB.we      = writePhase;
        reqB.addr    = idxHi;
        reqB.wdata.c = outB;
    end

    assign lastBfly = writePhase && stage == fftPkg::nStages - 1 && pair == '1;

    ////////////////////////////////////////
    // read / write sequence
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            running    <= 1'b0;
            writePhase <= 1'b0;
            stage      <= '0;
            pair       <= '0;
            engineDone <= 1'b0;
        end else begin
            engineDone <= running && grant && lastBfly;
            if (start && !running)
                running <= 1'b1;
            else if (running && grant) begin
                writePhase <= !writePhase;
                if (writePhase) begin
                    pair <= pair + 1'b1;
                    if (pair == '1)
                        stage <= stage + 1'b1;      // wraps to 0 after the last stage
                    if (lastBfly)
                        running <= 1'b0;
                end
            end
        end
    end

    twiddleRom twRom (
        .clk     (clk),
        .index   (twIdx),
        .inverse (inverse),
        .twiddle (twiddle)
    );

    butterflyUnit bfly (
        .a       (rdA.c),
        .b       (rdB.c),
        .twiddle (twiddle),
        .outA    (outA),
        .outB    (outB)
    );

endmodule

`default_nettype wire

// File: sampleLoader.sv
`timescale 1ns/10ps
`default_nettype none

module sampleLoader (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        loadStrobe,
    input  wire logic [31:0] dataIn,
    output fftPkg::memReq_t  req,
    input  wire logic        grant,
    output logic             loadDone
);

    logic [fftPkg::addrBits-1:0] count;     // samples written so far
    logic [fftPkg::addrBits-1:0] revAddr;
    logic [31:0]                 hold;      // refused sample waits here
    logic                        pending;
    logic                        capture;
    logic                        wrNow;

    always_comb begin
        for (int i = 0; i < fftPkg::addrBits; i++)
            revAddr[i] = count[fftPkg::addrBits-1-i];
    end

    always_comb begin
        req.req       = pending | loadStrobe;
        req.we        = 1'b1;
        req.addr      = revAddr;                // bit-reversed for the DIT stages
        req.wdata.raw = pending ? hold : dataIn;
    end

    assign wrNow   = req.req & grant;
    assign capture = loadStrobe & (pending | ~grant);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            count    <= '0;
            pending  <= 1'b0;
            loadDone <= 1'b0;
        end else begin
            pending  <= capture | (pending & ~grant);
            loadDone <= wrNow && count == fftPkg::nPoints - 1;
            if (wrNow)
                count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture)
            hold <= dataIn;
    end

endmodule

`default_nettype wire

// File: resultUnloader.sv
`timescale 1ns/10ps
`default_nettype none

module resultUnloader (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             start,
    output fftPkg::memReq_t       req,
    input  wire logic             grant,
    input  wire fftPkg::ramWord_u rdData,
    output logic [31:0]           dataOut,
    output logic                  outValid,
    output logic                  unloadDone
);

    logic                        running;
    logic [fftPkg::addrBits-1:0] addr;      // natural order
    logic                        lastRd;    // last read is in flight

    always_comb begin
        req.req       = running;
        req.we        = 1'b0;
        req.addr      = addr;
        req.wdata.raw = '0;
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            running  <= 1'b0;
            addr     <= '0;
            outValid <= 1'b0;
            lastRd   <= 1'b0;
        end else begin
            outValid <= running & grant;    // our read returns next cycle
            lastRd   <= running && grant && addr == fftPkg::nPoints - 1;
            if (start) begin
                running <= 1'b1;
                addr    <= '0;
            end else if (running && grant) begin
                addr <= addr + 1'b1;
                if (addr == fftPkg::nPoints - 1)
                    running <= 1'b0;
            end
        end
    end

    assign dataOut    = rdData.raw;
    assign unloadDone = outValid & lastRd;

endmodule

`default_nettype wire

// File: ramArbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ramArbiter (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire fftPkg::memReq_t engA,
    input  wire fftPkg::memReq_t engB,
    input  wire fftPkg::memReq_t ldA,
    input  wire fftPkg::memReq_t unB,
    output logic                 engGrant,
    output logic                 ldGrant,
    output logic                 unGrant,
    output fftPkg::memReq_t      portA,
    output fftPkg::memReq_t      portB
);

    logic engPendQ;     // ports stay reserved while an engine read returns

    ////////////////////////////////////////
    // fixed priority of engine over unloader over loader
    assign engGrant = engA.req | engB.req;
    assign unGrant  = unB.req & ~engB.req & ~engPendQ;
    assign ldGrant  = ldA.req & ~engA.req & ~engPendQ;

    always_comb begin
        portA = '0;
        portB = '0;
        if (engGrant) begin
            portA = engA;
            portB = engB;
        end else begin
            if (ldGrant)
                portA = ldA;
            if (unGrant)
                portB = unB;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            engPendQ <= 1'b0;
        else
            engPendQ <= engGrant & ~engA.we;
    end

endmodule

`default_nettype wire

// File: sampleRam.sv
`timescale 1ns/10ps
`default_nettype none

module sampleRam (
    input  wire logic            clk,
    input  wire fftPkg::memReq_t portA,
    input  wire fftPkg::memReq_t portB,
    output fftPkg::ramWord_u     rdA,
    output fftPkg::ramWord_u     rdB
);

    fftPkg::ramWord_u mem [fftPkg::nPoints];

    // read word holds its value during a write
    always_ff @(posedge clk) begin
        if (portA.req && portA.we)
            mem[portA.addr] <= portA.wdata;
        else
            rdA <= mem[portA.addr];
        if (portB.req && portB.we)
            mem[portB.addr] <= portB.wdata;
        else
            rdB <= mem[portB.addr];
    end

endmodule

`default_nettype wire

// File: fftAccel.sv
`timescale 1ns/10ps
`default_nettype none

module fftAccel (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        loadStrobe,
    input  wire logic [31:0] dataIn,
    input  wire logic        startF,
    input  wire logic        startI,
    input  wire logic [7:0]  frameTag,
    output logic             inReady,
    output logic             busy,
    output logic             done,
    output logic [31:0]      dataOut,
    output logic             outValid,
    output logic [7:0]       tagOut
);

    typedef enum logic [1:0] {sLoading, sLoaded, sComputing, sUnloading} seqState_t;

    seqState_t        state;
    logic             startAcc;
    logic             invQ;         // accepted start was an IFFT
    logic [7:0]       tagQ;
    logic             ldStrobe;
    logic             loadDone;
    logic             engineDone;
    logic             unloadDone;
    logic             engGrant;
    logic             ldGrant;
    logic             unGrant;
    fftPkg::memReq_t  engA;
    fftPkg::memReq_t  engB;
    fftPkg::memReq_t  ldReq;
    fftPkg::memReq_t  unReq;
    fftPkg::memReq_t  portA;
    fftPkg::memReq_t  portB;
    fftPkg::ramWord_u rdA;
    fftPkg::ramWord_u rdB;

    ////////////////////////////////////////
    // sequencing
    assign inReady  = state == sLoading && !loadDone;
    assign ldStrobe = loadStrobe & inReady;         // strobes outside loading are dropped
    assign startAcc = state == sLoaded && (startF || startI);
    assign busy     = state == sComputing || state == sUnloading;
    assign done     = engineDone;
    assign tagOut   = tagQ;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= sLoading;
            invQ  <= 1'b0;
            tagQ  <= '0;
        end else begin
            case (state)
                sLoading: begin
                    if (loadDone)
                        state <= sLoaded;
                end
                sLoaded: begin
                    if (startAcc) begin
                        state <= sComputing;
                        invQ  <= startI;
                        tagQ  <= frameTag;  // echoed with the results
                    end
                end
                sComputing: begin
                    if (engineDone)
                        state <= sUnloading;
                end
                default: begin
                    if (unloadDone)
                        state <= sLoading;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // peers and shared memory
    sampleLoader loader (
        .clk        (clk),
        .rst        (rst),
        .loadStrobe (ldStrobe),
        .dataIn     (dataIn),
        .req        (ldReq),
        .grant      (ldGrant),
        .loadDone   (loadDone)
    );

    fftEngine engine (
        .clk        (clk),
        .rst        (rst),
        .start      (startAcc),
        .inverse    (invQ),
        .reqA       (engA),
        .reqB       (engB),
        .grant      (engGrant),
        .rdA        (rdA),
        .rdB        (rdB),
        .engineDone (engineDone)
    );

    resultUnloader unloader (
        .clk        (clk),
        .rst        (rst),
        .start      (engineDone),
        .req        (unReq),
        .grant      (unGrant),
        .rdData     (rdB),
        .dataOut    (dataOut),
        .outValid   (outValid),
        .unloadDone (unloadDone)
    );

    ramArbiter arbiter (
        .clk      (clk),
        .rst      (rst),
        .engA     (engA),
        .engB     (engB),
        .ldA      (ldReq),
        .unB      (unReq),
        .engGrant (engGrant),
        .ldGrant  (ldGrant),
        .unGrant  (unGrant),
        .portA    (portA),
        .portB    (portB)
    );

    sampleRam ram (
        .clk   (clk),
        .portA (portA),
        .portB (portB),
        .rdA   (rdA),
        .rdB   (rdB)
    );

endmodule

`default_nettype wire

// File: tbFftModel.svh
`ifndef TB_FFT_MODEL_SVH
`define TB_FFT_MODEL_SVH

localparam real pi = 3.14159265358979;

int frameRe [16];       // time-domain frame in sample order
int frameIm [16];
int binRe   [16];       // expected result in natural bin order
int binIm   [16];

function automatic int roundReal(input real r);
    if (r >= 0.0)
        return $rtoi(r + 0.5);
    else
        return -$rtoi(0.5 - r);
endfunction

// keep the low 16 bits as a signed value
function automatic int wrap16(input int x);
    int r;
    r = x & 32'h0000ffff;
    if (r > 32767)
        r = r - 65536;
    return r;
endfunction

function automatic int bitRev4(input int n);
    return ((n & 1) << 3) | ((n & 2) << 1) | ((n & 4) >> 1) | ((n & 8) >> 3);
endfunction

// bit-exact 16-point radix-2 DIT transform in Q1.15 with truncation
task automatic modelTransform(input bit inverse);
    int span;
    int base;
    int lo;
    int hi;
    int k;
    int wRe;
    int wIm;
    int tRe;
    int tIm;
    int aRe;
    int aIm;
    for (int n = 0; n < 16; n++) begin
        binRe[bitRev4(n)] = frameRe[n];
        binIm[bitRev4(n)] = frameIm[n];
    end
    for (span = 1; span < 16; span = span * 2) begin
        for (base = 0; base < 16; base = base + 2 * span) begin
            for (int j = 0; j < span; j++) begin
                k   = j * (8 / span);                   // W16 exponent
                wRe = roundReal(32767.0 * $cos(2.0 * pi * k / 16.0));
                wIm = -roundReal(32767.0 * $sin(2.0 * pi * k / 16.0));
                if (inverse)
                    wIm = -wIm;                         // conjugate
                lo  = base + j;
                hi  = lo + span;
                tRe = ((binRe[hi] * wRe) >>> 15) - ((binIm[hi] * wIm) >>> 15);
                tIm = ((binRe[hi] * wIm) >>> 15) + ((binIm[hi] * wRe) >>> 15);
                aRe = binRe[lo];
                aIm = binIm[lo];
                binRe[lo] = wrap16((aRe + tRe) >>> 1);  // halved every stage
                binIm[lo] = wrap16((aIm + tIm) >>> 1);
                binRe[hi] = wrap16((aRe - tRe) >>> 1);
                binIm[hi] = wrap16((aIm - tIm) >>> 1);
            end
        end
    end
endtask

`endif

// File: tbFftAccel.sv
`timescale 1ns/10ps
`default_nettype none

module tbFftAccel;

    localparam int cycleLimit = 1000;   // six frames of about 120 cycles each
    localparam int roundTol   = 8;      // round trip error allowed, in LSB

    logic        clk;
    logic        rst;
    logic        loadStrobe;
    logic [31:0] dataIn;
    logic        startF;
    logic        startI;
    logic [7:0]  frameTag;
    logic        inReady;
    logic        busy;
    logic        done;
    logic [31:0] dataOut;
    logic        outValid;
    logic [7:0]  tagOut;

    int          errors;
    int          cycles;
    logic [15:0] lfsr;
    logic [31:0] result [16];           // words collected from the DUT
    logic [31:0] saved  [16];

    `include "tbFftModel.svh"

    fftAccel fftAccel_inst (
        .clk        (clk),
        .rst        (rst),
        .loadStrobe (loadStrobe),
        .dataIn     (dataIn),
        .startF     (startF),
        .startI     (startI),
        .frameTag   (frameTag),
        .inReady    (inReady),
        .busy       (busy),
        .done       (done),
        .dataOut    (dataOut),
        .outValid   (outValid),
        .tagOut     (tagOut)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("TIMEOUT: accelerator stopped responding, %0d errors so far", errors);
            $display("Finished with errors");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic int randomBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int randomSigned(input int n);
        int v;
        v = randomBits(n);
        if (v >= (1 << (n - 1)))
            v = v - (1 << n);
        return v;
    endfunction

    function automatic logic [31:0] packWord(input int re, input int im);
        return {im[15:0], re[15:0]};
    endfunction

    function automatic int reOf(input logic [31:0] w);
        return int'($signed(w[15:0]));
    endfunction

    function automatic int imOf(input logic [31:0] w);
        return int'($signed(w[31:16]));
    endfunction

    function automatic int absInt(input int x);
        return (x < 0) ? -x : x;
    endfunction

    task automatic loadFrame(input bit withGaps);
        int gap;
        for (int n = 0; n < 16; n++) begin
            if (!inReady) begin
                $display("MISMATCH at %0t: inReady low before sample %0d", $time, n);
                errors++;
            end
            loadStrobe = 1'b1;
            dataIn     = packWord(frameRe[n], frameIm[n]);
            @(negedge clk);
            loadStrobe = 1'b0;
            dataIn     = '0;
            if (withGaps) begin
                gap = randomBits(2);                    // 0 to 3 idle cycles
                repeat (gap) @(negedge clk);
            end
        end
        while (inReady)
            @(negedge clk);
        @(negedge clk);                                 // now in the loaded state
    endtask

    task automatic runFrame(input bit inverse, input logic [7:0] tag, input bit strobeBusy);
        int nDone;
        int nOut;
        nDone    = 0;
        nOut     = 0;
        frameTag = tag;
        startF   = !inverse;
        startI   = inverse;
        @(negedge clk);
        startF   = 1'b0;
        startI   = 1'b0;
        frameTag = ~tag;                                // must not reach tagOut
        if (!busy) begin
            $display("ERROR at %0t: busy did not rise after the start pulse", $time);
            errors++;
        end
        while (busy) begin
            if (done)
                nDone++;
            if (outValid) begin
                if (nOut < 16)
                    result[nOut] = dataOut;
                if (tagOut !== tag) begin
                    $display("MISMATCH at %0t: tagOut %h, expected %h", $time, tagOut, tag);
                    errors++;
                end
                nOut++;
            end
            if (strobeBusy) begin
                loadStrobe = 1'(randomBits(1));         // junk that must be dropped
                dataIn     = {16'(randomBits(16)), 16'(randomBits(16))};
            end
            @(negedge clk);
        end
        loadStrobe = 1'b0;
        dataIn     = '0;
        if (nDone != 1) begin
            $display("ERROR at %0t: saw %0d done pulses instead of one", $time, nDone);
            errors++;
        end
        if (nOut != 16) begin
            $display("ERROR at %0t: saw %0d result words instead of 16", $time, nOut);
            errors++;
        end
        if (!inReady) begin
            $display("MISMATCH at %0t: inReady low after the last result", $time);
            errors++;
        end
    endtask

    task automatic compareWithModel(input bit inverse, input string name);
        modelTransform(inverse);
        for (int k = 0; k < 16; k++) begin
            if (reOf(result[k]) != binRe[k] || imOf(result[k]) != binIm[k]) begin
                $display("MISMATCH at %0t: %s bin %0d got (%0d,%0d) expected (%0d,%0d)",
                         $time, name, k, reOf(result[k]), imOf(result[k]), binRe[k], binIm[k]);
                errors++;
            end
        end
    endtask

    function automatic void randomFrame();
        for (int n = 0; n < 16; n++) begin
            frameRe[n] = randomSigned(14);
            frameIm[n] = randomSigned(14);
        end
    endfunction

    ////////////////////////////////////////
    // directed tests

    task automatic resetStatusTest();
        if (!inReady || busy || done || outValid) begin
            $display("MISMATCH at %0t: after reset inReady %b busy %b done %b outValid %b",
                     $time, inReady, busy, done, outValid);
            errors++;
        end
    endtask

    task automatic impulseTest();
        for (int n = 0; n < 16; n++) begin
            frameRe[n] = (n == 0) ? 16384 : 0;
            frameIm[n] = 0;
        end
        loadFrame(1'b0);
        runFrame(1'b0, 8'h11, 1'b0);
        compareWithModel(1'b0, "impulse");
        for (int k = 0; k < 16; k++) begin
            if (reOf(result[k]) != 1024 || imOf(result[k]) != 0) begin
                $display("MISMATCH at %0t: impulse bin %0d is not (1024,0)", $time, k);
                errors++;
            end
        end
    endtask

    task automatic toneTest();
        for (int n = 0; n < 16; n++) begin
            frameRe[n] = roundReal(16000.0 * $cos(2.0 * pi * 3.0 * n / 16.0));
            frameIm[n] = 0;
        end
        loadFrame(1'b0);
        runFrame(1'b0, 8'h22, 1'b0);
        compareWithModel(1'b0, "tone");
        for (int k = 0; k < 16; k++) begin
            if (k == 3 || k == 13) begin
                if (reOf(result[k]) < 7000) begin
                    $display("MISMATCH at %0t: tone bin %0d lacks energy", $time, k);
                    errors++;
                end
            end else if (absInt(reOf(result[k])) > 200 || absInt(imOf(result[k])) > 200) begin
                $display("MISMATCH at %0t: tone bin %0d should be near zero", $time, k);
                errors++;
            end
        end
    endtask

    task automatic inverseTest();
        randomFrame();
        for (int n = 0; n < 16; n++)
            saved[n] = packWord(frameRe[n], frameIm[n]);
        loadFrame(1'b0);
        runFrame(1'b0, 8'h33, 1'b0);
        compareWithModel(1'b0, "forward");
        for (int n = 0; n < 16; n++) begin
            frameRe[n] = reOf(result[n]);               // spectrum goes back in
            frameIm[n] = imOf(result[n]);
        end
        loadFrame(1'b0);
        runFrame(1'b1, 8'h44, 1'b0);
        compareWithModel(1'b1, "inverse");
        for (int n = 0; n < 16; n++) begin
            if (absInt(reOf(result[n]) - reOf(saved[n]) / 16) > roundTol ||
                absInt(imOf(result[n]) - imOf(saved[n]) / 16) > roundTol) begin
                $display("MISMATCH at %0t: round trip sample %0d is far from input/16",
                         $time, n);
                errors++;
            end
        end
    endtask

    task automatic gapTest();
        randomFrame();
        loadFrame(1'b0);
        runFrame(1'b0, 8'h55, 1'b1);                    // strobes while busy
        compareWithModel(1'b0, "back-to-back");
        saved = result;
        loadFrame(1'b1);
        runFrame(1'b0, 8'h66, 1'b0);
        compareWithModel(1'b0, "gapped");
        for (int k = 0; k < 16; k++) begin
            if (result[k] !== saved[k]) begin
                $display("MISMATCH at %0t: gapped load differs at bin %0d", $time, k);
                errors++;
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        loadStrobe = 1'b0;
        dataIn     = '0;
        startF     = 1'b0;
        startI     = 1'b0;
        frameTag   = '0;
        errors     = 0;
        cycles     = 0;
        lfsr       = 16'd80;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        resetStatusTest();
        impulseTest();
        toneTest();
        inverseTest();
        gapTest();
        $display("tests complete, %0d errors", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
fftPkg.sv
twiddleRom.sv
butterflyUnit.sv
fftEngine.sv
sampleLoader.sv
resultUnloader.sv
ramArbiter.sv
sampleRam.sv
fftAccel.sv
tbFftAccel.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbFftAccel -f sim.f -o tbFftAccel
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tbFftAccel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
